// ==== include/dnc_sort_config.svh ====
// DNC allocation sort configuration
// Widths and vector length shared by the package, RTL and testbench

`ifndef DNC_SORT_CONFIG_SVH
`define DNC_SORT_CONFIG_SVH

// Width of one usage value u(j)
`define DNC_DATA_SIZE 16

// Largest vector length N
`define DNC_MAX_N 8

// Width of an index j and of N
// Must hold the value DNC_MAX_N itself
`define DNC_INDEX_SIZE 4

`endif

// ==== rtl/dnc_sort_pkg.sv ====
// DNC allocation sort types
// Element record and the array that moves between the three stages

`default_nettype none

`include "dnc_sort_config.svh"

package dnc_sort_pkg;

  ////////////////////////////////////////////////////////////
  // Element record
  ////////////////////////////////////////////////////////////

  // One slot of the free list
  // valid marks a captured element, unused slots sort last
  // index keeps the original position j through the sort
  typedef struct packed {
    logic                         valid;
    logic [`DNC_DATA_SIZE-1:0]    usage;
    logic [`DNC_INDEX_SIZE-1:0]   index;
  } dnc_elem_t;

  ////////////////////////////////////////////////////////////
  // Sort array
  ////////////////////////////////////////////////////////////

  // Full vector of DNC_MAX_N slots
  // Slot 0 holds phi(0) once sorted
  // Loader fills slots 0 to N-1, the rest stay invalid
  typedef dnc_elem_t [`DNC_MAX_N-1:0] dnc_sort_array_t;

endpackage

`default_nettype wire

// ==== rtl/dnc_sort_loader.sv ====
// DNC allocation sort decode stage
// Accepts START, latches the clamped length N and captures the
// streamed usage values u(j) together with their index j

`default_nettype none

`include "dnc_sort_config.svh"

module dnc_sort_loader (
  // Global
  input  wire                             CLK,
  input  wire                             RST,

  // Control
  input  wire                             START,
  input  wire                             U_IN_ENABLE,
  input  wire                             busy,
  output logic                            U_OUT_ENABLE,
  output logic                            load_done,

  // Data
  input  wire  [`DNC_INDEX_SIZE-1:0]      SIZE_N_IN,
  input  wire  [`DNC_DATA_SIZE-1:0]       U_IN,
  output logic [`DNC_INDEX_SIZE-1:0]      size_n,
  output dnc_sort_pkg::dnc_sort_array_t   load_array
);

  import dnc_sort_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    LOAD_IDLE,
    LOAD_CAPTURE
  } load_state_t;

  load_state_t                  state;

  // Slot written by the next strobe
  logic [`DNC_INDEX_SIZE-1:0]   cap_cnt;

  // N after clamping into 1 to DNC_MAX_N
  logic [`DNC_INDEX_SIZE-1:0]   size_clamped;

  logic                         start_accept;
  logic                         capture_strobe;
  logic                         last_capture;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // START only counts while nothing is loading or streaming
  assign start_accept   = (state == LOAD_IDLE) && START && !busy;
  assign capture_strobe = (state == LOAD_CAPTURE) && U_IN_ENABLE;
  assign last_capture   = capture_strobe && (cap_cnt == size_n - `DNC_INDEX_SIZE'(1));

  // Zero becomes one, oversize becomes DNC_MAX_N
  always_comb begin
    if (SIZE_N_IN == '0) begin
      size_clamped = `DNC_INDEX_SIZE'(1);
    end else if (SIZE_N_IN > `DNC_INDEX_SIZE'(`DNC_MAX_N)) begin
      size_clamped = `DNC_INDEX_SIZE'(`DNC_MAX_N);
    end else begin
      size_clamped = SIZE_N_IN;
    end
  end

  // Caller may stream while capturing
  assign U_OUT_ENABLE = (state == LOAD_CAPTURE);

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= LOAD_IDLE;
      cap_cnt   <= '0;
      size_n    <= `DNC_INDEX_SIZE'(1);
      load_done <= 1'b0;
    end else begin
      // Single cycle pulse
      load_done <= 1'b0;

      case (state)
        LOAD_IDLE: begin
          if (start_accept) begin
            size_n  <= size_clamped;
            cap_cnt <= '0;
            state   <= LOAD_CAPTURE;
          end
        end

        LOAD_CAPTURE: begin
          if (last_capture) begin
            // Nth element in, hand over to the sorter
            load_done <= 1'b1;
            state     <= LOAD_IDLE;
          end else if (capture_strobe) begin
            cap_cnt <= cap_cnt + `DNC_INDEX_SIZE'(1);
          end
        end

        default: begin
          state <= LOAD_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Element capture
  ////////////////////////////////////////////////////////////

  // Every slot starts invalid so short vectors sort cleanly
  always_ff @(posedge CLK) begin
    if (start_accept) begin
      load_array <= '0;
    end else if (capture_strobe) begin
      load_array[cap_cnt] <= dnc_elem_t'{valid: 1'b1, usage: U_IN, index: cap_cnt};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dnc_sort_vector.sv ====
// DNC allocation sort execute stage
// Sorts the element array in place with an odd-even transposition
// network, one compare-exchange pass per cycle for DNC_MAX_N passes
// phi(j) = sort(u(j)) with ties broken by lower index

`default_nettype none

`include "dnc_sort_config.svh"

module dnc_sort_vector (
  // Global
  input  wire                             CLK,
  input  wire                             RST,

  // Control
  input  wire                             start,
  output logic                            done,

  // Data
  input  wire dnc_sort_pkg::dnc_sort_array_t data_in,
  output dnc_sort_pkg::dnc_sort_array_t   data_out
);

  import dnc_sort_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Working copy sorted in place
  dnc_sort_array_t              work;
  dnc_sort_array_t              work_next;

  // Passes already applied
  logic [`DNC_INDEX_SIZE-1:0]   pass_cnt;
  logic                         running;

  // Odd pairs (1,2),(3,4).. when set and even pairs (0,1),(2,3).. when clear
  logic                         odd_phase;

  logic                         last_pass;

  ////////////////////////////////////////////////////////////
  // Ordering rule
  ////////////////////////////////////////////////////////////

  // True when a must sit before b
  // Valid before invalid
  // Then smaller usage
  // Then smaller index
  function automatic logic ranks_before(input dnc_elem_t a, input dnc_elem_t b);
    logic result;
    if (a.valid != b.valid) begin
      result = a.valid;
    end else if (!a.valid) begin
      // Two empty slots keep their order
      result = 1'b0;
    end else if (a.usage != b.usage) begin
      result = (a.usage < b.usage);
    end else begin
      result = (a.index < b.index);
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare-exchange network
  ////////////////////////////////////////////////////////////

  assign odd_phase = pass_cnt[0];

  // One pass of disjoint adjacent pairs
  // Reads only work so pairs never interfere
  always_comb begin
    work_next = work;
    for (int i = 0; i < `DNC_MAX_N - 1; i++) begin
      if (i[0] == odd_phase) begin
        // Swap when the upper slot outranks the lower
        if (ranks_before(work[i+1], work[i])) begin
          work_next[i]   = work[i+1];
          work_next[i+1] = work[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Pass control
  ////////////////////////////////////////////////////////////

  assign last_pass = (pass_cnt == `DNC_INDEX_SIZE'(`DNC_MAX_N - 1));

  // Load cycle then DNC_MAX_N passes with done rising on the last
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running  <= 1'b0;
      pass_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;

      if (start) begin
        // A new vector restarts the run
        running  <= 1'b1;
        pass_cnt <= '0;
      end else if (running) begin
        if (last_pass) begin
          running <= 1'b0;
          done    <= 1'b1;
        end else begin
          pass_cnt <= pass_cnt + `DNC_INDEX_SIZE'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Working array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      work <= data_in;
    end else if (running) begin
      work <= work_next;
    end
  end

  // Holds the sorted vector from done until the next start
  assign data_out = work;

endmodule

`default_nettype wire

// ==== rtl/dnc_sort_emitter.sv ====
// DNC allocation sort result stage
// Streams the sorted indices as phi, one per cycle, then pulses READY

`default_nettype none

`include "dnc_sort_config.svh"

module dnc_sort_emitter (
  // Global
  input  wire                             CLK,
  input  wire                             RST,

  // Control
  input  wire                             start,
  output logic                            busy,
  output logic                            PHI_OUT_ENABLE,
  output logic                            READY,

  // Data
  input  wire dnc_sort_pkg::dnc_sort_array_t data_in,
  input  wire  [`DNC_INDEX_SIZE-1:0]      size_n,
  output logic [`DNC_INDEX_SIZE-1:0]      PHI_OUT
);

  import dnc_sort_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Sorted vector held for the whole stream
  dnc_sort_array_t              phi_q;

  // Slot driven on the next cycle
  logic [`DNC_INDEX_SIZE-1:0]   out_cnt;

  // Streaming or about to start
  assign busy = start | PHI_OUT_ENABLE;

  ////////////////////////////////////////////////////////////
  // Output stream
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      PHI_OUT_ENABLE <= 1'b0;
      PHI_OUT        <= '0;
      READY          <= 1'b0;
      out_cnt        <= '0;
    end else begin
      READY <= 1'b0;

      if (start) begin
        // phi(0) straight from the sorter
        PHI_OUT_ENABLE <= 1'b1;
        PHI_OUT        <= data_in[0].index;
        out_cnt        <= `DNC_INDEX_SIZE'(1);
      end else if (PHI_OUT_ENABLE) begin
        if (out_cnt == size_n) begin
          // All N out so READY follows
          PHI_OUT_ENABLE <= 1'b0;
          PHI_OUT        <= '0;
          READY          <= 1'b1;
        end else begin
          PHI_OUT <= phi_q[out_cnt].index;
          out_cnt <= out_cnt + `DNC_INDEX_SIZE'(1);
        end
      end
    end
  end

  // Capture the sorted array
  always_ff @(posedge CLK) begin
    if (start) begin
      phi_q <= data_in;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dnc_sort_top.sv ====
// DNC allocation sort top level
// Loader, sorter and emitter in a fixed-latency chain
// Nth usage strobe to first phi takes DNC_MAX_N + 3 cycles

`default_nettype none

`include "dnc_sort_config.svh"

module dnc_sort_top (
  // Global
  input  wire                          CLK,
  input  wire                          RST,

  // Control
  input  wire                          START,
  input  wire                          U_IN_ENABLE,
  output logic                         READY,
  output logic                         U_OUT_ENABLE,
  output logic                         PHI_OUT_ENABLE,

  // Data
  input  wire  [`DNC_INDEX_SIZE-1:0]   SIZE_N_IN,
  input  wire  [`DNC_DATA_SIZE-1:0]    U_IN,
  output logic [`DNC_INDEX_SIZE-1:0]   PHI_OUT
);

  import dnc_sort_pkg::*;

  ////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////

  // Loader to sorter
  dnc_sort_array_t              load_array;
  logic                         load_done;

  // Sorter to emitter
  dnc_sort_array_t              sort_array;
  logic                         sort_done;

  // Latched N, emitter stream length
  logic [`DNC_INDEX_SIZE-1:0]   size_n;

  // Emitter streaming, blocks START
  logic                         busy;

  ////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////

  // Decode
  dnc_sort_loader loader (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .U_IN_ENABLE  (U_IN_ENABLE),
    .busy         (busy),
    .U_OUT_ENABLE (U_OUT_ENABLE),
    .load_done    (load_done),
    .SIZE_N_IN    (SIZE_N_IN),
    .U_IN         (U_IN),
    .size_n       (size_n),
    .load_array   (load_array)
  );

  // Execute
  dnc_sort_vector sorter (
    .CLK      (CLK),
    .RST      (RST),
    .start    (load_done),
    .done     (sort_done),
    .data_in  (load_array),
    .data_out (sort_array)
  );

  // Result
  dnc_sort_emitter emitter (
    .CLK            (CLK),
    .RST            (RST),
    .start          (sort_done),
    .busy           (busy),
    .PHI_OUT_ENABLE (PHI_OUT_ENABLE),
    .READY          (READY),
    .data_in        (sort_array),
    .size_n         (size_n),
    .PHI_OUT        (PHI_OUT)
  );

endmodule

`default_nettype wire

// ==== verification/dnc_sort_checker.sv ====
// DNC allocation sort protocol checker
// Concurrent assertions on the strobes and the phi range,
// bound into the top level

`default_nettype none

`include "dnc_sort_config.svh"

module dnc_sort_checker (
  input wire                         CLK,
  input wire                         RST,
  input wire                         U_OUT_ENABLE,
  input wire                         PHI_OUT_ENABLE,
  input wire                         READY,
  input wire [`DNC_INDEX_SIZE-1:0]   PHI_OUT,
  input wire [`DNC_INDEX_SIZE-1:0]   size_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far, read by the testbench
  int assert_fails = 0;

  ////////////////////////////////////////////////////////////
  // Strobe rules
  ////////////////////////////////////////////////////////////

  // Capture window and phi stream never overlap
  assert property (@(posedge CLK) disable iff (RST) !(U_OUT_ENABLE && PHI_OUT_ENABLE))
    else begin
      $error("U_OUT_ENABLE and PHI_OUT_ENABLE high in the same cycle");
      assert_fails++;
    end

  // READY is a single cycle pulse
  assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else begin
      $error("READY held high for more than one cycle");
      assert_fails++;
    end

  // READY only right after the last phi
  assert property (@(posedge CLK) disable iff (RST) READY |-> $fell(PHI_OUT_ENABLE))
    else begin
      $error("READY without PHI_OUT_ENABLE falling one cycle before");
      assert_fails++;
    end

  ////////////////////////////////////////////////////////////
  // Phi range
  ////////////////////////////////////////////////////////////

  // Every phi is an index of the latched vector
  assert property (@(posedge CLK) disable iff (RST) PHI_OUT_ENABLE |-> (PHI_OUT < size_n))
    else begin
      $error("PHI_OUT %0d not below latched N %0d", PHI_OUT, size_n);
      assert_fails++;
    end

endmodule

bind dnc_sort_top dnc_sort_checker protocol_check (
  .CLK            (CLK),
  .RST            (RST),
  .U_OUT_ENABLE   (U_OUT_ENABLE),
  .PHI_OUT_ENABLE (PHI_OUT_ENABLE),
  .READY          (READY),
  .PHI_OUT        (PHI_OUT),
  .size_n         (size_n)
);

`default_nettype wire

// ==== verification/dnc_sort_tb.sv ====
// DNC allocation sort testbench
// Table cases and seeded random vectors against a reference stable sort,
// plus latency, length and ignored START checks

`default_nettype none

`include "dnc_sort_config.svh"

module dnc_sort_tb;

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  // Slot 0 first in both lists, unused slots zero
  typedef struct packed {
    logic [`DNC_INDEX_SIZE-1:0]                   size_in;
    logic                                         inject;
    logic [0:`DNC_MAX_N-1][`DNC_DATA_SIZE-1:0]    usage;
    logic [0:`DNC_MAX_N-1][`DNC_INDEX_SIZE-1:0]   phi;
  } vec_case_t;

  localparam int NUM_CASES  = 8;
  localparam int NUM_RANDOM = 200;
  localparam int TIMEOUT    = 100;
  localparam int LATENCY    = `DNC_MAX_N + 3;

  localparam vec_case_t CASES [NUM_CASES] = '{
    '{size_in: 5, inject: 0, usage: '{30, 10, 50, 20, 40, 0, 0, 0}, phi: '{1, 3, 0, 4, 2, 0, 0, 0}},
    '{size_in: 8, inject: 1, usage: '{1, 2, 3, 4, 5, 6, 7, 8}, phi: '{0, 1, 2, 3, 4, 5, 6, 7}},
    '{size_in: 8, inject: 0, usage: '{80, 70, 60, 50, 40, 30, 20, 10}, phi: '{7, 6, 5, 4, 3, 2, 1, 0}},
    '{size_in: 6, inject: 0, usage: '{5, 5, 5, 5, 5, 5, 0, 0}, phi: '{0, 1, 2, 3, 4, 5, 0, 0}},
    '{size_in: 6, inject: 1, usage: '{3, 1, 3, 1, 2, 1, 0, 0}, phi: '{1, 3, 5, 4, 0, 2, 0, 0}},
    '{size_in: 1, inject: 0, usage: '{42, 0, 0, 0, 0, 0, 0, 0}, phi: '{0, 0, 0, 0, 0, 0, 0, 0}},
    '{size_in: 0, inject: 0, usage: '{7, 0, 0, 0, 0, 0, 0, 0}, phi: '{0, 0, 0, 0, 0, 0, 0, 0}},
    '{size_in: 12, inject: 0, usage: '{9, 2, 9, 2, 5, 5, 0, 1}, phi: '{6, 7, 1, 3, 4, 5, 0, 2}}
  };

  string names [NUM_CASES] = '{"distinct", "ascending", "descending", "all_equal",
                               "ties", "single", "zero_length", "oversize"};

  ////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////

  logic                         CLK = 1'b0;
  logic                         RST;
  logic                         START;
  logic                         U_IN_ENABLE;
  logic [`DNC_INDEX_SIZE-1:0]   SIZE_N_IN;
  logic [`DNC_DATA_SIZE-1:0]    U_IN;
  logic                         READY;
  logic                         U_OUT_ENABLE;
  logic                         PHI_OUT_ENABLE;
  logic [`DNC_INDEX_SIZE-1:0]   PHI_OUT;

  int errors;
  int checks;
  int vec_usage [`DNC_MAX_N];
  int exp_phi [`DNC_MAX_N];

  always #10 CLK = ~CLK;

  dnc_sort_top dut (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .U_IN_ENABLE    (U_IN_ENABLE),
    .READY          (READY),
    .U_OUT_ENABLE   (U_OUT_ENABLE),
    .PHI_OUT_ENABLE (PHI_OUT_ENABLE),
    .SIZE_N_IN      (SIZE_N_IN),
    .U_IN           (U_IN),
    .PHI_OUT        (PHI_OUT)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Drive and sample point, outputs settled
  task automatic step();
    @(posedge CLK);
    #2;
  endtask

  task automatic check_value(input string name, input string what, input int expected,
                             input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("ERROR %s %s: expected %0d, actual %0d", name, what, expected, actual);
    end
  endtask

  // Length 0 means 1, oversize means DNC_MAX_N
  function automatic int clamp_len(input int size_in);
    if (size_in == 0) return 1;
    if (size_in > `DNC_MAX_N) return `DNC_MAX_N;
    return size_in;
  endfunction

  // Stable insertion sort on usage, equal values keep lower index first
  task automatic ref_sort(input int n);
    int key;
    int k;
    for (int j = 0; j < n; j++) exp_phi[j] = j;
    for (int j = 1; j < n; j++) begin
      key = exp_phi[j];
      k   = j - 1;
      while (k >= 0 && vec_usage[exp_phi[k]] > vec_usage[key]) begin
        exp_phi[k+1] = exp_phi[k];
        k--;
      end
      exp_phi[k+1] = key;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One vector through the DUT
  ////////////////////////////////////////////////////////////

  task automatic run_vector(input string name, input int size_in, input bit gaps,
                            input bit inject);
    int n;
    int timer;
    int latency;
    int count;
    n         = clamp_len(size_in);
    START     = 1'b1;
    SIZE_N_IN = size_in[`DNC_INDEX_SIZE-1:0];
    step();
    START = 1'b0;
    timer = 0;
    while (!U_OUT_ENABLE && timer < TIMEOUT) begin
      step();
      timer++;
    end
    assert (U_OUT_ENABLE) else begin
      errors++;
      $display("Timeout in %s, U_OUT_ENABLE never rose after START", name);
    end
    if (!U_OUT_ENABLE) return;
    for (int j = 0; j < n; j++) begin
      // Idle gap, junk on U_IN must not be captured
      if (gaps && $urandom_range(0, 2) == 0) begin
        U_IN_ENABLE = 1'b0;
        U_IN        = '1;
        step();
      end
      U_IN_ENABLE = 1'b1;
      U_IN        = `DNC_DATA_SIZE'(vec_usage[j]);
      step();
    end
    U_IN_ENABLE = 1'b0;
    check_value(name, "U_OUT_ENABLE after Nth element", 0, U_OUT_ENABLE);
    // Count from the cycle of the Nth strobe
    latency = 1;
    while (!PHI_OUT_ENABLE && latency < TIMEOUT) begin
      step();
      latency++;
    end
    assert (PHI_OUT_ENABLE) else begin
      errors++;
      $display("Timeout in %s, PHI_OUT_ENABLE never rose after the last element", name);
    end
    if (!PHI_OUT_ENABLE) return;
    check_value(name, "latency", LATENCY, latency);
    count = 0;
    while (PHI_OUT_ENABLE && count < TIMEOUT) begin
      if (count < n) check_value(name, $sformatf("phi(%0d)", count), exp_phi[count], PHI_OUT);
      check_value(name, "U_OUT_ENABLE while streaming", 0, U_OUT_ENABLE);
      // START mid stream must be ignored
      START = inject && (count == 1);
      if (START) SIZE_N_IN = 3;
      step();
      count++;
    end
    START = 1'b0;
    check_value(name, "phi count", n, count);
    check_value(name, "READY after last phi", 1, READY);
    step();
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    RST         = 1'b1;
    START       = 1'b0;
    SIZE_N_IN   = '0;
    U_IN_ENABLE = 1'b0;
    U_IN        = '0;
    errors      = 0;
    checks      = 0;
    void'($urandom(32'hb73f49e2));
    repeat (16) @(posedge CLK);
    #2;
    check_value("reset", "READY", 0, READY);
    check_value("reset", "U_OUT_ENABLE", 0, U_OUT_ENABLE);
    check_value("reset", "PHI_OUT_ENABLE", 0, PHI_OUT_ENABLE);
    check_value("reset", "PHI_OUT", 0, PHI_OUT);
    RST = 1'b0;
    step();
    // Directed table
    for (int t = 0; t < NUM_CASES; t++) begin
      for (int j = 0; j < `DNC_MAX_N; j++) begin
        vec_usage[j] = CASES[t].usage[j];
        exp_phi[j]   = CASES[t].phi[j];
      end
      run_vector(names[t], CASES[t].size_in, 1'b0, CASES[t].inject);
    end
    // Small value range so ties are common
    for (int r = 0; r < NUM_RANDOM; r++) begin
      n = $urandom_range(1, `DNC_MAX_N);
      for (int j = 0; j < `DNC_MAX_N; j++) vec_usage[j] = (j < n) ? $urandom_range(0, 3) : 0;
      ref_sort(n);
      run_vector($sformatf("random_%0d", r), n, 1'b1, 1'b0);
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut.protocol_check.assert_fails);
    if (errors == 0 && dut.protocol_check.assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dnc_sort.f ====
+incdir+include
rtl/dnc_sort_pkg.sv
rtl/dnc_sort_loader.sv
rtl/dnc_sort_vector.sv
rtl/dnc_sort_emitter.sv
rtl/dnc_sort_top.sv
verification/dnc_sort_checker.sv
verification/dnc_sort_tb.sv
